// File: all.f
design/memPkg.sv
design/memPortIf.sv
design/dataPort.sv
design/fetchPort.sv
design/memCtrl.sv
design/ramBlock.sv
design/memTop.sv
test/memTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memTb
FILELIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// File: test/memTb.sv
`timescale 1ns/1ns
`default_nettype none

module memTb import memPkg::*; ();

    localparam int ramBytes      = 4096;
    localparam int ramAw         = $clog2(ramBytes);
    localparam int fetchWords    = 64;           // Fetch window starts at address 0.
    localparam int dataBase      = ramBytes / 2;
    localparam int dataWords     = 32;
    localparam int timeoutCycles = 600 * 12 + 500;

    typedef struct packed {
        dataT data;
        tagT  tag;
        int   bytes;
        logic timed;                             // Latency must be exact.
        int   startAt;
    } dataExpT;

    typedef struct packed {
        dataT data;
        int   mode;                              // 0 any, 1 hit, 2 miss.
        int   startAt;
    } fetchExpT;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic lsuValid;
    logic lsuStore;
    addrT lsuAddr;
    dataT lsuWdata;
    lenT  lsuLen;
    tagT  lsuTag;
    logic lsuReady;
    logic lsuDone;
    dataT lsuRdata;
    tagT  lsuTagOut;
    logic fetchValid;
    addrT fetchAddr;
    logic fetchReady;
    logic fetchDone;
    dataT fetchInstr;

    logic [7:0] refMem [ramBytes];
    dataExpT    dataQ[$];
    fetchExpT   fetchQ[$];
    integer     seed = 32'ha571_f068;
    tagT        nextTag;
    int         cycleCount = 0;
    int         rdyCount = 0;                    // Edges with rdy high.
    int         dataDoneAt = 0;
    int         fetchDoneAt = 0;

    always #5 clk = ~clk;

    memTop #(
        .icacheLines (16),
        .ramBytes    (ramBytes)
    ) i_memTop (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .lsuValid   (lsuValid),
        .lsuStore   (lsuStore),
        .lsuAddr    (lsuAddr),
        .lsuWdata   (lsuWdata),
        .lsuLen     (lsuLen),
        .lsuTag     (lsuTag),
        .lsuReady   (lsuReady),
        .lsuDone    (lsuDone),
        .lsuRdata   (lsuRdata),
        .lsuTagOut  (lsuTagOut),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInstr (fetchInstr)
    );

    // **************************************************
    // Reference model
    // **************************************************

    function automatic int numBytes(input lenT len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic dataT refLoad(input addrT addr, input lenT len);
        dataT             val;
        logic [ramAw-1:0] pos;
        val = '0;                                // Upper bytes stay zero.
        for (int i = 0; i < numBytes(len); i++) begin
            pos = ramAw'(addr + addrT'(i));      // Wraps at the RAM size.
            val[8*i +: 8] = refMem[pos];
        end
        return val;
    endfunction

    function automatic void refStore(input addrT addr, input dataT data, input lenT len);
        logic [ramAw-1:0] pos;
        for (int i = 0; i < numBytes(len); i++) begin
            pos = ramAw'(addr + addrT'(i));
            refMem[pos] = data[8*i +: 8];
        end
    endfunction

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAIL at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        abortRun();
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        abortRun();
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (rdy) begin
            rdyCount = rdyCount + 1;
        end
        if (cycleCount >= timeoutCycles) begin
            reportProblem("timeout, the tests did not finish in time");
        end
    end

    // **************************************************
    // Checker at the falling edge
    // **************************************************

    always @(negedge clk) begin : check
        dataExpT  dE;
        fetchExpT fE;
        int       lat;
        if (rst) begin
            assert (!lsuDone && !fetchDone) else reportProblem("done pulse during reset");
        end else begin
            if (lsuDone) begin
                assert (dataQ.size() > 0) else reportProblem("lsuDone with no request waiting");
                dE = dataQ.pop_front();
                assert (lsuRdata === dE.data) else reportMismatch("lsuRdata", lsuRdata, dE.data);
                assert (lsuTagOut === dE.tag)
                    else reportMismatch("lsuTagOut", 32'(lsuTagOut), 32'(dE.tag));
                lat = rdyCount - dE.startAt + 1;
                if (dE.timed) begin
                    assert (lat == dE.bytes + 2)
                        else reportMismatch("lsuDone latency", lat, dE.bytes + 2);
                end
                dataDoneAt = cycleCount;
            end
            if (fetchDone) begin
                assert (fetchQ.size() > 0) else reportProblem("fetchDone with no fetch waiting");
                fE = fetchQ.pop_front();
                assert (fetchInstr === fE.data)
                    else reportMismatch("fetchInstr", fetchInstr, fE.data);
                lat = rdyCount - fE.startAt + 1;
                if (fE.mode == 1) begin
                    assert (lat == 1) else reportMismatch("fetchDone hit latency", lat, 1);
                end
                if (fE.mode == 2) begin
                    assert (lat > 1) else reportProblem("a fetch that should miss hit the cache");
                end
                fetchDoneAt = cycleCount;
            end
        end
    end

    // **************************************************
    // Stimulus
    // **************************************************

    // Presents a data request and/or a fetch and returns once both are taken.
    task automatic issueOps(input logic doData, input logic store, input addrT dAddr,
                            input dataT wdata, input lenT len, input logic timed,
                            input logic doFetch, input addrT fAddr, input int mode);
        dataExpT  dE;
        fetchExpT fE;
        logic     dTaken;
        logic     fTaken;
        logic     dGo;
        logic     fGo;
        dTaken     = !doData;
        fTaken     = !doFetch;
        lsuValid   = doData;
        lsuStore   = store;
        lsuAddr    = dAddr;
        lsuWdata   = wdata;
        lsuLen     = len;
        lsuTag     = nextTag;
        fetchValid = doFetch;
        fetchAddr  = fAddr;
        while (!(dTaken && fTaken)) begin
            @(negedge clk);
            dGo = lsuValid && lsuReady;
            fGo = fetchValid && fetchReady;
            @(posedge clk);
            #1;
            if (dGo) begin
                dE.data    = store ? '0 : refLoad(dAddr, len);
                dE.tag     = nextTag;
                dE.bytes   = numBytes(len);
                dE.timed   = timed;
                dE.startAt = rdyCount;
                if (store) begin
                    refStore(dAddr, wdata, len);
                end
                dataQ.push_back(dE);
                nextTag  = nextTag + 4'd1;
                lsuValid = 1'b0;
                dTaken   = 1'b1;
            end
            if (fGo) begin
                fE.data    = refLoad({fAddr[addrWidth-1:2], 2'b00}, lenWord);
                fE.mode    = mode;
                fE.startAt = rdyCount;
                fetchQ.push_back(fE);
                fetchValid = 1'b0;
                fTaken     = 1'b1;
            end
        end
    endtask

    task automatic waitIdle();
        @(posedge clk);
        #1;
        while (dataQ.size() != 0 || fetchQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fetchAndWait(input addrT addr, input int mode);
        issueOps(1'b0, 1'b0, '0, '0, lenByte, 1'b0, 1'b1, addr, mode);
        waitIdle();
    endtask

    initial begin
        dataT word;
        addrT addr;
        lenT  len;
        int   pick;
        rst        = 1'b1;
        rdy        = 1'b1;
        lsuValid   = 1'b0;
        lsuStore   = 1'b0;
        lsuAddr    = '0;
        lsuWdata   = '0;
        lsuLen     = lenByte;
        lsuTag     = '0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        nextTag    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        assert (lsuReady && fetchReady && !lsuDone && !fetchDone)
            else reportProblem("ports not ready in the first cycle after reset");
        @(posedge clk);
        #1;

        // Fill the fetch window, then the data window.
        for (int i = 0; i < fetchWords; i++) begin
            issueOps(1'b1, 1'b1, addrT'(4 * i), dataT'($random(seed)), lenWord, 1'b1,
                     1'b0, '0, 0);
        end
        for (int i = 0; i < dataWords; i++) begin
            issueOps(1'b1, 1'b1, addrT'(dataBase + 4 * i), dataT'($random(seed)), lenWord,
                     1'b1, 1'b0, '0, 0);
        end

        // Store then load each length with fetch idle.
        for (int l = 0; l < 3; l++) begin
            len = lenT'(l);
            repeat (4) begin
                addr = addrT'(dataBase + {$random(seed)} % (4 * dataWords - 3));
                issueOps(1'b1, 1'b1, addr, dataT'($random(seed)), len, 1'b1, 1'b0, '0, 0);
                issueOps(1'b1, 1'b0, addr, '0, len, 1'b1, 1'b0, '0, 0);
            end
        end
        waitIdle();

        fetchAndWait(addrT'('h10), 2);
        fetchAndWait(addrT'('h10), 1);
        fetchAndWait(addrT'('h50), 2);           // Same line, other tag.
        fetchAndWait(addrT'('h50), 1);

        // Data load and fetch miss in the same cycle.
        issueOps(1'b1, 1'b0, addrT'(dataBase + 8), '0, lenWord, 1'b1, 1'b1, addrT'('h10), 2);
        waitIdle();
        assert (dataDoneAt < fetchDoneAt)
            else reportProblem("lsuDone did not come before fetchDone");

        // Pause in the middle of both accesses.
        issueOps(1'b1, 1'b0, addrT'(dataBase + 6), '0, lenHalf, 1'b1, 1'b1, addrT'('h90), 2);
        @(posedge clk);
        #1;
        rdy = 1'b0;
        repeat (6) begin
            @(negedge clk);
            assert (!lsuDone && !fetchDone && !lsuReady && !fetchReady)
                else reportProblem("ports active while rdy is low");
        end
        @(posedge clk);
        #1;
        rdy = 1'b1;
        waitIdle();

        // Random mix of both streams.
        repeat (250) begin
            pick = {$random(seed)} % 3;          // 0 data, 1 fetch, 2 both.
            len  = lenT'({$random(seed)} % 3);
            addr = addrT'(dataBase + {$random(seed)} % (4 * dataWords - 3));
            word = dataT'($random(seed));
            issueOps(pick != 1, word[31], addr, word, len, 1'b0,
                     pick != 0, addrT'(4 * ({$random(seed)} % fetchWords)), 0);
        end
        waitIdle();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/memTop.sv
`timescale 1ns/1ns
`default_nettype none

module memTop import memPkg::*; #(
    parameter int icacheLines = 16,
    parameter int ramBytes    = 4096
) (
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    input  logic lsuValid,
    input  logic lsuStore,
    input  addrT lsuAddr,
    input  dataT lsuWdata,
    input  lenT  lsuLen,
    input  tagT  lsuTag,
    output logic lsuReady,
    output logic lsuDone,
    output dataT lsuRdata,
    output tagT  lsuTagOut,

    input  logic fetchValid,
    input  addrT fetchAddr,
    output logic fetchReady,
    output logic fetchDone,
    output dataT fetchInstr
);

    logic       ramEn;
    logic       ramWe;
    addrT       ramAddr;
    logic [7:0] ramWdata;
    logic [7:0] ramRdata;

    memPortIf dataIf ();
    memPortIf fetchIf ();

    dataPort i_dataPort (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .lsuValid  (lsuValid),
        .lsuStore  (lsuStore),
        .lsuAddr   (lsuAddr),
        .lsuWdata  (lsuWdata),
        .lsuLen    (lsuLen),
        .lsuTag    (lsuTag),
        .lsuReady  (lsuReady),
        .lsuDone   (lsuDone),
        .lsuRdata  (lsuRdata),
        .lsuTagOut (lsuTagOut),
        .mem       (dataIf.port)
    );

    fetchPort #(
        .icacheLines (icacheLines)
    ) i_fetchPort (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInstr (fetchInstr),
        .mem        (fetchIf.port)
    );

    // **************************************************
    // Shared RAM behind the arbiter
    // **************************************************

    memCtrl i_memCtrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .dPort    (dataIf.controller),
        .iPort    (fetchIf.controller),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    ramBlock #(
        .ramBytes (ramBytes)
    ) i_ramBlock (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

`default_nettype wire

// File: design/ramBlock.sv
`timescale 1ns/1ns
`default_nettype none

module ramBlock import memPkg::*; #(
    parameter int ramBytes = 4096
) (
    input  logic       clk,

    input  logic       ramEn,
    input  logic       ramWe,
    input  addrT       ramAddr,
    input  logic [7:0] ramWdata,
    output logic [7:0] ramRdata
);

    localparam int ramAw = $clog2(ramBytes);

    logic [7:0]       mem [ramBytes];
    logic [ramAw-1:0] wrapAddr;

    assign wrapAddr = ramAw'(ramAddr % addrT'(ramBytes)); // Wraps around the array.

    // **************************************************
    // Write at the edge, registered read
    // **************************************************

    always_ff @(posedge clk) begin
        if (ramEn && ramWe) begin
            mem[wrapAddr] <= ramWdata;
        end
    end

    // Holds its value while ramEn is low.
    always_ff @(posedge clk) begin
        if (ramEn) begin
            ramRdata <= mem[wrapAddr];
        end
    end

endmodule

`default_nettype wire

// File: design/memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrl import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,

    memPortIf.controller dPort,
    memPortIf.controller iPort,

    output logic        ramEn,
    output logic        ramWe,
    output addrT        ramAddr,
    output logic [7:0]  ramWdata,
    input  logic [7:0]  ramRdata
);

    function automatic logic [2:0] byteCount(lenT len);
        case (len)
            lenByte: byteCount = 3'd1;
            lenHalf: byteCount = 3'd2;
            default: byteCount = 3'd4;
        endcase
    endfunction

    logic busy;
    logic ownerFetch;     // Owner of the running access.
    logic [2:0] idx;      // Cycles since grant.
    logic [2:0] count;    // Bytes in the access.
    logic curStore;
    addrT curAddr;
    logic [23:0] wShift;  // Store bytes still to go out.
    dataT acc;            // Load bytes gathered so far.

    logic grantD, grantI, grantAny;
    logic selStore;
    addrT selAddr;
    dataT selWdata;
    lenT  selLen;
    logic issueNow, captureNow, doneNow;

    // **************************************************
    // Fixed-priority arbiter
    // **************************************************

    assign grantD   = rdy & ~busy & dPort.req; // Data port first.
    assign grantI   = rdy & ~busy & ~dPort.req & iPort.req;
    assign grantAny = grantD | grantI;

    always_comb begin
        if (grantD) begin
            selStore = dPort.store;
            selAddr  = dPort.addr;
            selWdata = dPort.wdata;
            selLen   = dPort.len;
        end else begin
            selStore = iPort.store;
            selAddr  = iPort.addr;
            selWdata = iPort.wdata;
            selLen   = iPort.len;
        end
    end

    // **************************************************
    // Byte sequencer
    // **************************************************

    assign issueNow   = busy & (idx < count);
    assign captureNow = busy & (idx <= count); // Byte idx-1 on ramRdata.
    assign doneNow    = rdy & busy & (idx == count + 3'd1);

    assign ramEn    = rdy & (grantAny | issueNow);
    assign ramWe    = ramEn & (busy ? curStore : selStore);
    assign ramAddr  = busy ? curAddr + addrT'(idx) : selAddr;
    assign ramWdata = busy ? wShift[7:0] : selWdata[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            ownerFetch <= 1'b0;
            idx        <= 3'd0;
        end else if (rdy) begin
            if (grantAny) begin
                busy       <= 1'b1;
                ownerFetch <= grantI;
                idx        <= 3'd1; // Byte 0 went out with the grant.
            end else if (busy) begin
                idx <= idx + 3'd1;
                if (doneNow) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (grantAny) begin
                curStore <= selStore;
                curAddr  <= selAddr;
                count    <= byteCount(selLen);
                wShift   <= selWdata[31:8];
                acc      <= '0;
            end else if (busy) begin
                if (issueNow) begin
                    wShift <= wShift >> 8;
                end
                if (captureNow && !curStore) begin
                    acc[{idx[1:0] - 2'd1, 3'b000} +: 8] <= ramRdata;
                end
            end
        end
    end

    assign dPort.grant = grantD;
    assign iPort.grant = grantI;
    assign dPort.done  = doneNow & ~ownerFetch;
    assign iPort.done  = doneNow & ownerFetch;
    assign dPort.rdata = curStore ? '0 : acc;
    assign iPort.rdata = curStore ? '0 : acc;

endmodule

`default_nettype wire

// File: design/fetchPort.sv
`timescale 1ns/1ns
`default_nettype none

module fetchPort import memPkg::*; #(
    parameter int icacheLines = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    fetchValid,
    input  addrT    fetchAddr,
    output logic    fetchReady,
    output logic    fetchDone,
    output dataT    fetchInstr,

    memPortIf.port  mem
);

    localparam int idxBits = $clog2(icacheLines);
    localparam int tagBits = addrWidth - 2 - idxBits;

    logic [icacheLines-1:0] lineValid;
    logic [tagBits-1:0]     lineTag [icacheLines];
    dataT                   lineData [icacheLines];

    logic [addrWidth-3:0] lookWord; // Word address under lookup.
    logic [idxBits-1:0]   lookIdx;
    logic [tagBits-1:0]   lookTag;
    logic lookValid;
    logic missReg;                  // Word load outstanding.
    logic reqReg;
    logic lineHit, hitNow, missNow, accept;

    assign lookIdx = lookWord[idxBits-1:0];
    assign lookTag = lookWord[addrWidth-3:idxBits];
    assign lineHit = lineValid[lookIdx] && (lineTag[lookIdx] == lookTag);
    assign hitNow  = lookValid & ~missReg & lineHit;
    assign missNow = lookValid & ~missReg & ~lineHit;

    assign fetchReady = rdy & ~missReg & ~missNow;
    assign accept     = fetchValid & fetchReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= '0; // All lines invalid.
            lookValid <= 1'b0;
            missReg   <= 1'b0;
            reqReg    <= 1'b0;
        end else if (rdy) begin
            if (accept) begin
                lookValid <= 1'b1;
            end else if (hitNow || mem.done) begin
                lookValid <= 1'b0;
            end
            if (missNow) begin
                missReg <= 1'b1;
                reqReg  <= 1'b1;
            end
            if (mem.grant) begin
                reqReg <= 1'b0;
            end
            if (mem.done) begin
                missReg            <= 1'b0;
                lineValid[lookIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                lookWord <= fetchAddr[addrWidth-1:2];
            end
            if (mem.done) begin
                lineTag[lookIdx]  <= lookTag;
                lineData[lookIdx] <= mem.rdata;
            end
        end
    end

    assign mem.req   = reqReg;
    assign mem.store = 1'b0; // Fetch only loads.
    assign mem.addr  = {lookWord, 2'b00};
    assign mem.wdata = '0;
    assign mem.len   = lenWord;

    assign fetchDone  = (rdy & hitNow) | mem.done;
    assign fetchInstr = missReg ? mem.rdata : lineData[lookIdx];

endmodule

`default_nettype wire

// File: design/dataPort.sv
`timescale 1ns/1ns
`default_nettype none

module dataPort import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    lsuValid,
    input  logic    lsuStore,
    input  addrT    lsuAddr,
    input  dataT    lsuWdata,
    input  lenT     lsuLen,
    input  tagT     lsuTag,
    output logic    lsuReady,
    output logic    lsuDone,
    output dataT    lsuRdata,
    output tagT     lsuTagOut,

    memPortIf.port  mem
);

    logic full;   // Entry holds a request.
    logic reqReg; // Not yet granted.
    logic accept;

    logic curStore;
    addrT curAddr;
    dataT curWdata;
    lenT  curLen;
    tagT  curTag;

    assign lsuReady = rdy & ~full;
    assign accept   = lsuValid & lsuReady;

    // **************************************************
    // Entry control
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            full   <= 1'b0;
            reqReg <= 1'b0;
        end else if (rdy) begin
            if (accept) begin
                full   <= 1'b1;
                reqReg <= 1'b1;
            end
            if (mem.grant) begin
                reqReg <= 1'b0;
            end
            if (mem.done) begin
                full <= 1'b0; // Free again next cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && accept) begin
            curStore <= lsuStore;
            curAddr  <= lsuAddr;
            curWdata <= lsuWdata;
            curLen   <= lsuLen;
            curTag   <= lsuTag;
        end
    end

    // **************************************************
    // Controller side and result
    // **************************************************

    assign mem.req   = reqReg;
    assign mem.store = curStore;
    assign mem.addr  = curAddr;
    assign mem.wdata = curWdata;
    assign mem.len   = curLen;

    assign lsuDone   = mem.done;
    assign lsuRdata  = mem.rdata;
    assign lsuTagOut = curTag; // Tag kept from the accepting edge.

endmodule

`default_nettype wire

// File: design/memPortIf.sv
`timescale 1ns/1ns
`default_nettype none

interface memPortIf import memPkg::*; ();

    logic req;   // Request waiting.
    logic store;
    addrT addr;
    dataT wdata;
    lenT  len;

    logic grant; // One-cycle pulse.
    logic done;  // One-cycle pulse.
    dataT rdata; // Little-endian, zero-extended.

    modport port (
        output req,
        output store,
        output addr,
        output wdata,
        output len,
        input  grant,
        input  done,
        input  rdata
    );

    modport controller (
        input  req,
        input  store,
        input  addr,
        input  wdata,
        input  len,
        output grant,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/memPkg.sv
`default_nettype none

package memPkg;

    // **************************************************
    // Bus widths
    // **************************************************

    localparam int addrWidth = 17; // Byte address.
    localparam int dataWidth = 32;
    localparam int lenWidth  = 2;
    localparam int tagWidth  = 4;  // One tag per load/store buffer entry.

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [dataWidth-1:0] dataT;
    typedef logic [tagWidth-1:0]  tagT;

    // **************************************************
    // Access length codes
    // **************************************************

    typedef enum logic [lenWidth-1:0] {
        lenByte = 2'd0, // 1 byte.
        lenHalf = 2'd1, // 2 bytes.
        lenWord = 2'd2  // 4 bytes.
    } lenT;

endpackage

`default_nettype wire
